//--- Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) $(VFLAGS)

# Exit status of the simulator is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- hw/decode.sv
`default_nettype none

module decode (
    input  wire logic              clk,
    input  wire logic              reset,

    // Upstream from fetch
    input  wire decode_pkg::word_t instr,
    input  wire decode_pkg::word_t pc_in,
    input  wire logic              valid_in,
    output logic                   ready_in,

    // Downstream to execute
    output decode_pkg::decoded_t   dec_out,
    output logic                   valid_out,
    input  wire logic              ready_out
);

    decode_pkg::decoded_t dec_next;

    decode_pkg::word_t    imm;
    decode_pkg::reg_idx_t rs1;
    decode_pkg::reg_idx_t rs2;
    decode_pkg::reg_idx_t rd;
    decode_pkg::opcode_t  opcode;
    decode_pkg::alu_op_e  alu_op;
    logic                 alt_op;
    logic                 fu_mem;
    logic                 fu_alu;
    logic                 illegal;

    logic load_main;
    logic load_skid;
    logic skid_to_main;

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    signal_decode u_signal_decode (
        .instr   (instr),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .opcode  (opcode),
        .alu_op  (alu_op),
        .alt_op  (alt_op),
        .fu_mem  (fu_mem),
        .fu_alu  (fu_alu),
        .illegal (illegal)
    );

    // Combinational decode of the instruction at the input
    always_comb begin
        dec_next.pc      = pc_in;
        dec_next.rs1     = rs1;
        dec_next.rs2     = rs2;
        dec_next.rd      = rd;
        dec_next.imm     = imm;
        dec_next.opcode  = opcode;
        dec_next.alu_op  = alu_op;
        dec_next.alt_op  = alt_op;
        dec_next.fu_mem  = fu_mem;
        dec_next.fu_alu  = fu_alu;
        dec_next.illegal = illegal;
    end

    decode_ctrl u_decode_ctrl (
        .clk          (clk),
        .reset        (reset),
        .valid_in     (valid_in),
        .ready_out    (ready_out),
        .ready_in     (ready_in),
        .valid_out    (valid_out),
        .load_main    (load_main),
        .load_skid    (load_skid),
        .skid_to_main (skid_to_main)
    );

    decode_buffer u_decode_buffer (
        .clk          (clk),
        .reset        (reset),
        .dec_next     (dec_next),
        .load_main    (load_main),
        .load_skid    (load_skid),
        .skid_to_main (skid_to_main),
        .dec_out      (dec_out)
    );

endmodule

`default_nettype wire

//--- hw/decode_buffer.sv
`default_nettype none

module decode_buffer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire decode_pkg::decoded_t dec_next,
    input  wire logic                 load_main,
    input  wire logic                 load_skid,
    input  wire logic                 skid_to_main,
    output decode_pkg::decoded_t      dec_out
);

    // Main entry is what downstream sees
    decode_pkg::decoded_t main_q;
    decode_pkg::decoded_t skid_q;
    decode_pkg::decoded_t main_d;

    // Older skid packet wins so ordering holds
    always_comb begin
        if (skid_to_main) begin
            main_d = skid_q;
        end else if (load_main) begin
            main_d = dec_next;
        end else begin
            main_d = main_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            main_q <= '0;
        end else begin
            main_q <= main_d;
        end
    end

    // Skid only fills while main is stalled downstream
    always_ff @(posedge clk) begin
        if (reset) begin
            skid_q <= '0;
        end else if (load_skid) begin
            skid_q <= dec_next;
        end
    end

    assign dec_out = main_q;

endmodule

`default_nettype wire

//--- hw/decode_ctrl.sv
`default_nettype none

module decode_ctrl (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic valid_in,
    input  wire logic ready_out,
    output logic      ready_in,
    output logic      valid_out,
    output logic      load_main,
    output logic      load_skid,
    output logic      skid_to_main
);

    decode_pkg::decode_state_e state;
    decode_pkg::decode_state_e state_next;

    logic accept;
    logic drain;

    // Handshake outputs depend on the state register alone
    assign ready_in  = (state != decode_pkg::DEC_TWO);
    assign valid_out = (state != decode_pkg::DEC_EMPTY);

    assign accept = valid_in && ready_in;
    assign drain  = valid_out && ready_out;

    always_comb begin
        state_next   = state;
        load_main    = 1'b0;
        load_skid    = 1'b0;
        skid_to_main = 1'b0;

        case (state)
            decode_pkg::DEC_EMPTY: begin
                if (accept) begin
                    load_main  = 1'b1;
                    state_next = decode_pkg::DEC_ONE;
                end
            end
            decode_pkg::DEC_ONE: begin
                if (accept && drain) begin
                    // Main is replaced in the same edge it is consumed
                    load_main = 1'b1;
                end else if (accept) begin
                    load_skid  = 1'b1;
                    state_next = decode_pkg::DEC_TWO;
                end else if (drain) begin
                    state_next = decode_pkg::DEC_EMPTY;
                end
            end
            decode_pkg::DEC_TWO: begin
                // No accept possible here since ready_in is low
                if (drain) begin
                    skid_to_main = 1'b1;
                    state_next   = decode_pkg::DEC_ONE;
                end
            end
            default: begin
                state_next = decode_pkg::DEC_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= decode_pkg::DEC_EMPTY;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_pkg.sv
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    // Widths with a meaning in the decode stage
    typedef logic [`DECODE_XLEN-1:0] word_t;
    typedef logic [`DECODE_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [6:0] opcode_t;

    // RV32I major opcodes handled by this stage
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // Encodings follow funct3, so the decoder can cast directly
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_e;

    // Number of packets held in the output buffer
    typedef enum logic [1:0] {
        DEC_EMPTY = 2'd0,
        DEC_ONE   = 2'd1,
        DEC_TWO   = 2'd2
    } decode_state_e;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        opcode_t  opcode;
        alu_op_e  alu_op;
        logic     alt_op;
        logic     fu_mem;
        logic     fu_alu;
        logic     illegal;
    } decoded_t;

endpackage

`default_nettype wire

//--- hw/imm_gen.sv
`default_nettype none

module imm_gen (
    input  wire decode_pkg::word_t instr,
    output decode_pkg::word_t      imm
);

    decode_pkg::opcode_t opc;
    logic                sign;

    // One candidate per instruction format
    decode_pkg::word_t imm_i;
    decode_pkg::word_t imm_s;
    decode_pkg::word_t imm_b;
    decode_pkg::word_t imm_u;
    decode_pkg::word_t imm_j;

    assign opc  = instr[6:0];
    assign sign = instr[31];

    // Shift amounts sit in the low bits with funct7 above them
    assign imm_i = {{20{sign}}, instr[31:20]};
    assign imm_s = {{20{sign}}, instr[31:25], instr[11:7]};

    // Branch and jump offsets are halfword aligned
    assign imm_b = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opc)
            decode_pkg::OPC_OP_IMM,
            decode_pkg::OPC_LOAD,
            decode_pkg::OPC_JALR: begin
                imm = imm_i;
            end
            decode_pkg::OPC_STORE: begin
                imm = imm_s;
            end
            decode_pkg::OPC_BRANCH: begin
                imm = imm_b;
            end
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC: begin
                imm = imm_u;
            end
            decode_pkg::OPC_JAL: begin
                imm = imm_j;
            end
            // R type and unknown opcodes carry no immediate
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/signal_decode.sv
`default_nettype none

module signal_decode (
    input  wire decode_pkg::word_t instr,
    output decode_pkg::reg_idx_t   rs1,
    output decode_pkg::reg_idx_t   rs2,
    output decode_pkg::reg_idx_t   rd,
    output decode_pkg::opcode_t    opcode,
    output decode_pkg::alu_op_e    alu_op,
    output logic                   alt_op,
    output logic                   fu_mem,
    output logic                   fu_alu,
    output logic                   illegal
);

    decode_pkg::opcode_t  opc;
    decode_pkg::alu_op_e  funct3_op;
    decode_pkg::reg_idx_t rs1_field;
    decode_pkg::reg_idx_t rs2_field;
    decode_pkg::reg_idx_t rd_field;
    logic                 funct7_b5;
    logic                 is_shift;

    assign opc       = instr[6:0];
    assign rd_field  = instr[11:7];
    assign rs1_field = instr[19:15];
    assign rs2_field = instr[24:20];
    assign funct7_b5 = instr[30];

    // funct3 maps one to one onto the ALU operation
    assign funct3_op = decode_pkg::alu_op_e'(instr[14:12]);

    // SLLI, SRLI and SRAI keep funct7 in the immediate field
    assign is_shift = (funct3_op == decode_pkg::ALU_SLL) ||
                      (funct3_op == decode_pkg::ALU_SR);

    assign opcode = opc;

    always_comb begin
        rs1     = rs1_field;
        rs2     = '0;
        rd      = rd_field;
        alu_op  = decode_pkg::ALU_ADD;
        alt_op  = 1'b0;
        fu_mem  = 1'b0;
        fu_alu  = 1'b0;
        illegal = 1'b0;

        case (opc)
            decode_pkg::OPC_OP: begin
                rs2    = rs2_field;
                alu_op = funct3_op;
                alt_op = funct7_b5;
                fu_alu = 1'b1;
            end
            decode_pkg::OPC_OP_IMM: begin
                alu_op = funct3_op;
                alt_op = is_shift ? funct7_b5 : 1'b0;
                fu_alu = 1'b1;
            end
            decode_pkg::OPC_LOAD: begin
                fu_mem = 1'b1;
            end
            decode_pkg::OPC_STORE: begin
                rs2    = rs2_field;
                rd     = '0;
                fu_mem = 1'b1;
            end
            // Comparison type comes from funct3 as well
            decode_pkg::OPC_BRANCH: begin
                rs2    = rs2_field;
                rd     = '0;
                alu_op = funct3_op;
                fu_alu = 1'b1;
            end
            decode_pkg::OPC_JALR: begin
                fu_alu = 1'b1;
            end
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC,
            decode_pkg::OPC_JAL: begin
                rs1    = '0;
                fu_alu = 1'b1;
            end
            // FENCE, SYSTEM and anything else land here
            default: begin
                rs1     = '0;
                rd      = '0;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Data, instruction and address word width
`define DECODE_XLEN 32

// Architectural register index width
// 32 integer registers in RV32I
`define DECODE_REG_IDX_W 5

`endif

//--- sim.f
+incdir+include
hw/decode_pkg.sv
hw/imm_gen.sv
hw/signal_decode.sv
hw/decode_ctrl.sv
hw/decode_buffer.sv
hw/decode.sv
sim/tb_decode.sv

//--- sim/decode_stimulus.hex
// instr pc rs1 rs2 rd imm opcode alu_op alt_op fu_mem fu_alu illegal
// R, I, shifts, loads, stores, branches, U, J, JALR, then unknown opcodes
002081b3 00001000 01 02 03 00000000 33 0 0 0 1 0
407302b3 00001004 06 07 05 00000000 33 0 1 0 1 0
00c59533 00001008 0b 0c 0a 00000000 33 1 0 0 1 0
003120b3 0000100c 02 03 01 00000000 33 2 0 0 1 0
0062b233 00001010 05 06 04 00000000 33 3 0 0 1 0
009443b3 00001014 08 09 07 00000000 33 4 0 0 1 0
00f756b3 00001018 0e 0f 0d 00000000 33 5 0 0 1 0
4128d833 0000101c 11 12 10 00000000 33 5 1 0 1 0
015a69b3 00001020 14 15 13 00000000 33 6 0 0 1 0
018bfb33 00001024 17 18 16 00000000 33 7 0 0 1 0
fff10093 00001028 02 00 01 ffffffff 13 0 0 0 1 0
8003a313 0000102c 07 00 06 fffff800 13 2 0 0 1 0
1234b413 00001030 09 00 08 00000123 13 3 0 0 1 0
5555c513 00001034 0b 00 0a 00000555 13 4 0 0 1 0
ff07f713 00001038 0f 00 0e fffffff0 13 7 0 0 1 0
00521193 0000103c 04 00 03 00000005 13 1 0 0 1 0
01fada13 00001040 15 00 14 0000001f 13 5 0 0 1 0
407d5c93 00001044 1a 00 19 00000407 13 5 1 0 1 0
00812483 00001048 02 00 09 00000008 03 0 0 1 0 0
7fefdf83 0000104c 1f 00 1f 000007fe 03 0 0 1 0 0
00532623 00001050 06 05 00 0000000c 23 0 0 1 0 0
fe740fa3 00001054 08 07 00 ffffffff 23 0 0 1 0 0
44951aa3 00001058 0a 09 00 00000455 23 0 0 1 0 0
00208463 0000105c 01 02 00 00000008 63 0 0 0 1 0
fe419ee3 00001060 03 04 00 fffffffc 63 1 0 0 1 0
0062c0e3 00001064 05 06 00 00000800 63 4 0 0 1 0
8083f063 00001068 07 08 00 fffff000 63 7 0 0 1 0
123452b7 0000106c 00 00 05 12345000 37 0 0 0 1 0
fffff517 00001070 00 00 0a fffff000 17 0 0 0 1 0
001000ef 00001074 00 00 01 00000800 6f 0 0 0 1 0
ff9ff06f 00001078 00 00 00 fffffff8 6f 0 0 0 1 0
010280e7 0000107c 05 00 01 00000010 67 0 0 0 1 0
ffff8067 00001080 1f 00 00 ffffffff 67 0 0 0 1 0
0ff0000f 00001084 00 00 00 00000000 0f 0 0 0 0 1
00000073 00001088 00 00 00 00000000 73 0 0 0 0 1
ffffffff 0000108c 00 00 00 00000000 7f 0 0 0 0 1
// End marker
a5a5a5a5

//--- sim/tb_decode.sv
`default_nettype none

`include "decode_config.svh"

module tb_decode;

    // Each stimulus line holds twelve words, then one end marker word
    localparam int num_vec     = 36;
    localparam int vec_words   = 12;
    localparam int stim_words  = num_vec * vec_words + 1;
    localparam int cycle_limit = num_vec * 20 + 100;

    logic                 clk;
    logic                 reset;
    decode_pkg::word_t    instr;
    decode_pkg::word_t    pc_in;
    logic                 valid_in;
    logic                 ready_in;
    decode_pkg::decoded_t dec_out;
    logic                 valid_out;
    logic                 ready_out;

    logic [`DECODE_XLEN-1:0] stim [0:stim_words-1];
    decode_pkg::decoded_t    expected_q [$];
    decode_pkg::decoded_t    held_pkt;
    logic                    stalled;
    logic                    holding;
    int                      next_vec;
    int                      delivered;
    int                      cycle_count;

    decode dut (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .pc_in     (pc_in),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .dec_out   (dec_out),
        .valid_out (valid_out),
        .ready_out (ready_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input decode_pkg::word_t got,
                              input decode_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input decode_pkg::reg_idx_t got,
                             input decode_pkg::reg_idx_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_opcode(input string name, input decode_pkg::opcode_t got,
                                input decode_pkg::opcode_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_alu(input string name, input decode_pkg::alu_op_e got,
                             input decode_pkg::alu_op_e exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_packet(input string tag, input decode_pkg::decoded_t got,
                                input decode_pkg::decoded_t exp);
        check_word({tag, ".pc"}, got.pc, exp.pc);
        check_reg({tag, ".rs1"}, got.rs1, exp.rs1);
        check_reg({tag, ".rs2"}, got.rs2, exp.rs2);
        check_reg({tag, ".rd"}, got.rd, exp.rd);
        check_word({tag, ".imm"}, got.imm, exp.imm);
        check_opcode({tag, ".opcode"}, got.opcode, exp.opcode);
        check_alu({tag, ".alu_op"}, got.alu_op, exp.alu_op);
        check_flag({tag, ".alt_op"}, got.alt_op, exp.alt_op);
        check_flag({tag, ".fu_mem"}, got.fu_mem, exp.fu_mem);
        check_flag({tag, ".fu_alu"}, got.fu_alu, exp.fu_alu);
        check_flag({tag, ".illegal"}, got.illegal, exp.illegal);
    endtask

    function automatic decode_pkg::decoded_t expected_packet(input int idx);
        decode_pkg::decoded_t pkt;
        int                   base;
        base        = idx * vec_words;
        pkt.pc      = stim[base + 1];
        pkt.rs1     = stim[base + 2][`DECODE_REG_IDX_W-1:0];
        pkt.rs2     = stim[base + 3][`DECODE_REG_IDX_W-1:0];
        pkt.rd      = stim[base + 4][`DECODE_REG_IDX_W-1:0];
        pkt.imm     = stim[base + 5];
        pkt.opcode  = stim[base + 6][6:0];
        pkt.alu_op  = decode_pkg::alu_op_e'(stim[base + 7][2:0]);
        pkt.alt_op  = stim[base + 8][0];
        pkt.fu_mem  = stim[base + 9][0];
        pkt.fu_alu  = stim[base + 10][0];
        pkt.illegal = stim[base + 11][0];
        return pkt;
    endfunction

    // One clock of stimulus and checks
    // Mode 0 streams, mode 1 stalls downstream and mode 2 is random
    task automatic step(input int mode, input int last, input int phase_step);
        logic offer;
        @(negedge clk);
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles, %0d of %0d packets delivered",
                               cycle_count, delivered, num_vec));
        end
        // A refused offer stays on the bus unchanged
        if (!holding) begin
            offer = 1'b0;
            if (next_vec <= last) begin
                offer = (mode != 2) || (($urandom % 3) != 0);
            end
            valid_in = offer;
            if (offer) begin
                instr = stim[next_vec * vec_words];
                pc_in = stim[next_vec * vec_words + 1];
            end
        end
        case (mode)
            0: ready_out = 1'b1;
            1: ready_out = (phase_step % 4) == 3;
            default: ready_out = ($urandom % 4) != 0;
        endcase
        // Outstanding packets equal the buffer occupancy
        check_flag("ready_in", ready_in, expected_q.size() < 2);
        check_flag("valid_out", valid_out, expected_q.size() != 0);
        if (stalled) begin
            check_packet("held dec_out", dec_out, held_pkt);
        end
        stalled  = valid_out && !ready_out;
        held_pkt = dec_out;
        if (valid_out && ready_out) begin
            check_packet("dec_out", dec_out, expected_q.pop_front());
            delivered++;
        end
        if (valid_in && ready_in) begin
            expected_q.push_back(expected_packet(next_vec));
            next_vec++;
        end
        holding = valid_in && !ready_in;
    endtask

    task automatic run_phase(input int mode, input int first, input int last);
        int steps;
        steps    = 0;
        next_vec = first;
        while (next_vec <= last || expected_q.size() != 0) begin
            step(mode, last, steps);
            steps++;
        end
    endtask

    initial begin
        void'($urandom(32'h33a4));
        reset       = 1'b1;
        instr       = '0;
        pc_in       = '0;
        valid_in    = 1'b0;
        ready_out   = 1'b0;
        held_pkt    = '0;
        stalled     = 1'b0;
        holding     = 1'b0;
        next_vec    = 0;
        delivered   = 0;
        cycle_count = 0;
        $readmemh("sim/decode_stimulus.hex", stim);
        if (stim[stim_words-1] !== 32'ha5a5a5a5) begin
            fail_run("Stimulus file is missing or does not hold the expected line count");
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;
        // Empty and ready before the first instruction
        check_flag("valid_out", valid_out, 1'b0);
        check_flag("ready_in", ready_in, 1'b1);
        check_packet("reset dec_out", dec_out, '0);
        run_phase(0, 0, 11);
        run_phase(1, 12, 23);
        run_phase(2, 24, num_vec - 1);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
